// File: include/tg_defs.svh
`ifndef TG_DEFS_SVH
`define TG_DEFS_SVH

// Avalon-MM widths seen by the memory controller
`define TG_ADDR_WIDTH        24
`define TG_BURSTCOUNT_WIDTH  7
// Bytes per data word, so a 4 KB page spans 512 words
`define TG_DATA_BYTES        8

// Command FIFO entries between generator and issuer
`define TG_FIFO_DEPTH        4

// Address alignment options of the burst-boundary block
`define TG_BURST_ON_BOUNDARY 1
`define TG_WORD_ADDR_DIV     2
`define TG_NO_4KB_CROSS      1

`endif

// File: verilog/tg_avl_pkg.sv
`default_nettype none

`include "tg_defs.svh"

////////////////////////////////////////////////////////////
// Avalon-MM side vector types
////////////////////////////////////////////////////////////
package tg_avl_pkg;

   // Word address as driven on avl_address
   typedef logic [`TG_ADDR_WIDTH-1:0] tg_addr_t;

   // Number of beats in one burst
   // Only powers of two up to 64 are used by the generator
   typedef logic [`TG_BURSTCOUNT_WIDTH-1:0] tg_burstcount_t;

   // One data beat on avl_writedata
   typedef logic [8*`TG_DATA_BYTES-1:0] tg_data_t;

endpackage

`default_nettype wire

// File: verilog/tg_cmd_pkg.sv
`default_nettype none

////////////////////////////////////////////////////////////
// Command types shared by generator, FIFO and issuer
////////////////////////////////////////////////////////////
package tg_cmd_pkg;

   import tg_avl_pkg::*;

   // Operation carried by a command
   typedef enum logic [0:0] {TG_OP_READ, TG_OP_WRITE} tg_op_e;

   // How the generator walks the address space
   typedef enum logic [0:0] {TG_MODE_SEQ, TG_MODE_RAND} tg_addr_mode_e;

   // One queued command, already aligned
   // 1 + 24 + 7 bits with the default widths
   typedef struct packed {
      tg_op_e         op;
      tg_addr_t       addr;
      tg_burstcount_t burstcount;
   } tg_cmd_t;

   // Generator FSM
   typedef enum logic [1:0] {GEN_IDLE, GEN_RUN, GEN_WAIT} tg_gen_state_e;

   // Issuer FSM
   typedef enum logic [1:0] {ISS_IDLE, ISS_READ, ISS_WRITE, ISS_FINISH} tg_iss_state_e;

endpackage

`default_nettype wire

// File: verilog/tg_burst_boundary_addr_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "tg_defs.svh"

module tg_burst_boundary_addr_gen
   import tg_avl_pkg::*;
#(
   parameter int BURST_ON_BURST_BOUNDARY   = `TG_BURST_ON_BOUNDARY,
   parameter int WORD_ADDRESS_DIVISIBLE_BY = `TG_WORD_ADDR_DIV,
   parameter int DO_NOT_CROSS_4KB_BOUNDARY = `TG_NO_4KB_CROSS,
   parameter int DATA_BYTES                = `TG_DATA_BYTES
)
(
   input  tg_burstcount_t burstcount,
   input  tg_addr_t       addr_in,
   output tg_addr_t       addr_out
);

   // Lowest word-address bit that selects a 4 KB page
   localparam int LOG_4KB = 12 - $clog2(DATA_BYTES);

   // Burstcount widened to the address width for the adders below
   tg_addr_t bc_ext;
   tg_addr_t addr_burst;
   tg_addr_t addr_word;

   assign bc_ext = tg_addr_t'(burstcount);

   generate
      ////////////////////////////////////////////////////////////
      // Stage 1 rounds up to the next burst boundary
      ////////////////////////////////////////////////////////////
      if (BURST_ON_BURST_BOUNDARY == 1)
      begin : g_burst_on
         // Burstcount is a power of two, so clearing the low bits rounds down
         // Adding a whole burst keeps sequential addresses strictly increasing
         assign addr_burst = (addr_in & ~(bc_ext - tg_addr_t'(1))) + bc_ext;
      end
      else
      begin : g_burst_off
         assign addr_burst = addr_in;
      end

      // Stage 2 rounds up to a word-address multiple that is a power of two
      if (WORD_ADDRESS_DIVISIBLE_BY > 1)
      begin : g_word_div
         localparam tg_addr_t WORD_DIV = tg_addr_t'(WORD_ADDRESS_DIVISIBLE_BY);
         // Round up past the current address and drop the low bits
         assign addr_word = (addr_burst + WORD_DIV) & ~(WORD_DIV - tg_addr_t'(1));
      end
      else
      begin : g_word_any
         assign addr_word = addr_burst;
      end

      // Stage 3 keeps the whole burst inside one 4 KB page
      if (DO_NOT_CROSS_4KB_BOUNDARY == 1)
      begin : g_4kb_on
         tg_addr_t last_addr;
         assign last_addr = addr_word + bc_ext - tg_addr_t'(1);
         // A crossing burst moves up by one burst into the next page
         assign addr_out = (addr_word[$bits(tg_addr_t)-1:LOG_4KB] !=
                            last_addr[$bits(tg_addr_t)-1:LOG_4KB]) ?
                           addr_word + bc_ext : addr_word;
      end
      else
      begin : g_4kb_off
         assign addr_out = addr_word;
      end
   endgenerate

endmodule

`default_nettype wire

// File: verilog/tg_addr_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tg_addr_gen
   import tg_avl_pkg::*, tg_cmd_pkg::*;
(
   input  logic           clk,
   input  logic           arst_n,
   input  logic           start,
   input  tg_addr_mode_e  cfg_mode,
   input  tg_op_e         cfg_op,
   input  tg_addr_t       cfg_base,
   input  tg_burstcount_t cfg_burstcount,
   input  logic [7:0]     cfg_num_cmds,
   input  logic           fifo_full,
   output logic           fifo_push,
   output tg_cmd_t        fifo_wdata,
   output logic           gen_busy
);

   // Galois feedback mask for x^24 + x^23 + x^22 + x^17 + 1
   localparam tg_addr_t LFSR_TAPS = tg_addr_t'(24'hE1_0000);

   tg_gen_state_e  state;
   tg_addr_mode_e  mode_q;
   tg_op_e         op_q;
   tg_burstcount_t bc_q;
   logic [7:0]     cmds_left;
   tg_addr_t       raw_addr;
   tg_addr_t       aligned_addr;
   tg_addr_t       lfsr_next;
   logic           last_cmd;

   // Alignment of the raw address happens in the same cycle as the push
   tg_burst_boundary_addr_gen i_align
   (
      .burstcount (bc_q),
      .addr_in    (raw_addr),
      .addr_out   (aligned_addr)
   );

   // One LFSR step, shifting right and folding bit 0 back into the taps
   assign lfsr_next = (raw_addr >> 1) ^ ({$bits(tg_addr_t){raw_addr[0]}} & LFSR_TAPS);

   // A push is offered in every active cycle and held back only by full
   assign fifo_push = (state != GEN_IDLE) && !fifo_full;
   assign gen_busy  = (state != GEN_IDLE);
   assign last_cmd  = (cmds_left == 8'd1);

   always_comb
   begin
      fifo_wdata.op         = op_q;
      fifo_wdata.addr       = aligned_addr;
      fifo_wdata.burstcount = bc_q;
   end

   ////////////////////////////////////////////////////////////
   // Control FSM and command counter
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state     <= GEN_IDLE;
         cmds_left <= '0;
      end
      else
      begin
         case (state)
            GEN_IDLE:
            begin
               // An empty run is ignored, there is nothing to push
               if (start && (cfg_num_cmds != 8'd0))
               begin
                  state     <= GEN_RUN;
                  cmds_left <= cfg_num_cmds;
               end
            end
            GEN_RUN, GEN_WAIT:
            begin
               if (fifo_push)
               begin
                  cmds_left <= cmds_left - 8'd1;
                  state     <= last_cmd ? GEN_IDLE : GEN_RUN;
               end
               else
               begin
                  // FIFO is full, stall until the issuer makes room
                  state <= GEN_WAIT;
               end
            end
            default:
            begin
               state <= GEN_IDLE;
            end
         endcase
      end
   end

   // Run configuration and the next raw address
   always_ff @(posedge clk)
   begin
      if (start && (state == GEN_IDLE))
      begin
         mode_q <= cfg_mode;
         op_q   <= cfg_op;
         bc_q   <= cfg_burstcount;
         // An all-zero seed would lock the LFSR, so it is replaced by 1
         if ((cfg_mode == TG_MODE_RAND) && (cfg_base == '0))
            raw_addr <= tg_addr_t'(1);
         else
            raw_addr <= cfg_base;
      end
      else if (fifo_push)
      begin
         // sequential runs continue right after the burst just issued
         if (mode_q == TG_MODE_SEQ)
            raw_addr <= aligned_addr + tg_addr_t'(bc_q);
         else
            raw_addr <= lfsr_next;
      end
   end

endmodule

`default_nettype wire

// File: verilog/tg_cmd_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "tg_defs.svh"

module tg_cmd_fifo
   import tg_cmd_pkg::*;
#(
   parameter int DEPTH = `TG_FIFO_DEPTH
)
(
   input  logic    clk,
   input  logic    arst_n,
   input  logic    push,
   input  tg_cmd_t wdata,
   input  logic    pop,
   output tg_cmd_t rdata,
   output logic    full,
   output logic    empty
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);
   localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);

   tg_cmd_t          mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;

   // Show-ahead output puts the head entry on rdata
   assign rdata = mem[rd_ptr];
   assign full  = (count == CNT_W'(DEPTH));
   assign empty = (count == '0);

   // Each push writes the entry at the write pointer
   always_ff @(posedge clk)
   begin
      if (push)
         mem[wr_ptr] <= wdata;
   end

   ////////////////////////////////////////////////////////////
   // Pointers and occupancy
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         // Pointers wrap explicitly so any depth works
         if (push)
            wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;

         // Simultaneous push and pop leave the count unchanged
         if (push && !pop)
            count <= count + 1'b1;
         else if (pop && !push)
            count <= count - 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: verilog/tg_avl_cmd_issuer.sv
`timescale 1ns/1ps
`default_nettype none

module tg_avl_cmd_issuer
   import tg_avl_pkg::*, tg_cmd_pkg::*;
(
   input  logic           clk,
   input  logic           arst_n,
   input  logic           fifo_empty,
   input  tg_cmd_t        fifo_rdata,
   input  logic           gen_busy,
   input  logic           avl_waitrequest,
   output logic           fifo_pop,
   output logic           avl_read,
   output logic           avl_write,
   output tg_addr_t       avl_address,
   output tg_burstcount_t avl_burstcount,
   output tg_data_t       avl_writedata,
   output logic           done
);

   tg_iss_state_e  state;
   tg_burstcount_t beat;
   logic           take_cmd;
   logic           last_beat;

   // A new head is taken whenever no burst is in flight
   assign take_cmd  = ((state == ISS_IDLE) || (state == ISS_FINISH)) && !fifo_empty;
   assign last_beat = (beat == avl_burstcount - tg_burstcount_t'(1));

   // The head leaves the FIFO on the cycle its last transfer is accepted
   assign fifo_pop = !avl_waitrequest &&
                     ((state == ISS_READ) || ((state == ISS_WRITE) && last_beat));

   // Beat k of a write carries the burst address plus k
   assign avl_writedata = tg_data_t'(avl_address) + tg_data_t'(beat);

   // The run is over when nothing is queued and nothing more will come
   assign done = (state == ISS_FINISH) && fifo_empty && !gen_busy;

   ////////////////////////////////////////////////////////////
   // Issue FSM
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state     <= ISS_IDLE;
         avl_read  <= 1'b0;
         avl_write <= 1'b0;
         beat      <= '0;
      end
      else
      begin
         case (state)
            ISS_IDLE, ISS_FINISH:
            begin
               if (take_cmd)
               begin
                  avl_read  <= (fifo_rdata.op == TG_OP_READ);
                  avl_write <= (fifo_rdata.op == TG_OP_WRITE);
                  beat      <= '0;
                  state     <= (fifo_rdata.op == TG_OP_READ) ? ISS_READ : ISS_WRITE;
               end
               else if (done)
               begin
                  state <= ISS_IDLE;
               end
            end
            ISS_READ:
            begin
               // One accepted read cycle requests the whole burst
               if (!avl_waitrequest)
               begin
                  avl_read <= 1'b0;
                  state    <= ISS_FINISH;
               end
            end
            ISS_WRITE:
            begin
               if (!avl_waitrequest)
               begin
                  if (last_beat)
                  begin
                     avl_write <= 1'b0;
                     state     <= ISS_FINISH;
                  end
                  else
                  begin
                     beat <= beat + tg_burstcount_t'(1);
                  end
               end
            end
            default:
            begin
               state <= ISS_IDLE;
            end
         endcase
      end
   end

   // Address and burst count stay put for the whole burst
   always_ff @(posedge clk)
   begin
      if (take_cmd)
      begin
         avl_address    <= fifo_rdata.addr;
         avl_burstcount <= fifo_rdata.burstcount;
      end
   end

endmodule

`default_nettype wire

// File: verilog/tg_top.sv
`timescale 1ns/1ps
`default_nettype none

module tg_top
   import tg_avl_pkg::*, tg_cmd_pkg::*;
(
   input  logic           clk,
   input  logic           arst_n,
   input  logic           start,
   input  tg_addr_mode_e  cfg_mode,
   input  tg_op_e         cfg_op,
   input  tg_addr_t       cfg_base,
   input  tg_burstcount_t cfg_burstcount,
   input  logic [7:0]     cfg_num_cmds,
   input  logic           avl_waitrequest,
   output logic           avl_read,
   output logic           avl_write,
   output tg_addr_t       avl_address,
   output tg_burstcount_t avl_burstcount,
   output tg_data_t       avl_writedata,
   output logic           done
);

   ////////////////////////////////////////////////////////////
   // Links between generator, FIFO and issuer
   ////////////////////////////////////////////////////////////
   logic    fifo_push;
   logic    fifo_pop;
   logic    fifo_full;
   logic    fifo_empty;
   tg_cmd_t fifo_wdata;
   tg_cmd_t fifo_rdata;
   logic    gen_busy;

   // Producer of aligned commands
   tg_addr_gen i_addr_gen
   (
      .clk            (clk),
      .arst_n         (arst_n),
      .start          (start),
      .cfg_mode       (cfg_mode),
      .cfg_op         (cfg_op),
      .cfg_base       (cfg_base),
      .cfg_burstcount (cfg_burstcount),
      .cfg_num_cmds   (cfg_num_cmds),
      .fifo_full      (fifo_full),
      .fifo_push      (fifo_push),
      .fifo_wdata     (fifo_wdata),
      .gen_busy       (gen_busy)
   );

   // Back-pressure from waitrequest builds up here
   tg_cmd_fifo i_cmd_fifo
   (
      .clk    (clk),
      .arst_n (arst_n),
      .push   (fifo_push),
      .wdata  (fifo_wdata),
      .pop    (fifo_pop),
      .rdata  (fifo_rdata),
      .full   (fifo_full),
      .empty  (fifo_empty)
   );

   // Avalon-MM master side
   tg_avl_cmd_issuer i_issuer
   (
      .clk             (clk),
      .arst_n          (arst_n),
      .fifo_empty      (fifo_empty),
      .fifo_rdata      (fifo_rdata),
      .gen_busy        (gen_busy),
      .avl_waitrequest (avl_waitrequest),
      .fifo_pop        (fifo_pop),
      .avl_read        (avl_read),
      .avl_write       (avl_write),
      .avl_address     (avl_address),
      .avl_burstcount  (avl_burstcount),
      .avl_writedata   (avl_writedata),
      .done            (done)
   );

endmodule

`default_nettype wire

// File: tests/tb_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "tg_defs.svh"

module tb_checker
   import tg_avl_pkg::*, tg_cmd_pkg::*;
(
   input  logic           clk,
   input  logic           arst_n,
   input  logic           start,
   input  tg_addr_mode_e  cfg_mode,
   input  tg_op_e         cfg_op,
   input  tg_addr_t       cfg_base,
   input  tg_burstcount_t cfg_burstcount,
   input  logic [7:0]     cfg_num_cmds,
   input  logic [95:0]    test_name,
   input  logic           avl_waitrequest,
   input  logic           avl_read,
   input  logic           avl_write,
   input  tg_addr_t       avl_address,
   input  tg_burstcount_t avl_burstcount,
   input  tg_data_t       avl_writedata,
   input  logic           done,
   output int             check_count,
   output int             error_count
);

   localparam tg_addr_t WORD_DIV   = tg_addr_t'(`TG_WORD_ADDR_DIV);
   // Words in one 4 KB page
   localparam tg_addr_t PAGE_WORDS = tg_addr_t'(4096 / `TG_DATA_BYTES);

   logic           active;
   logic [95:0]    cur_name;
   tg_addr_mode_e  cur_mode;
   tg_op_e         cur_op;
   tg_burstcount_t cur_bc;
   logic [7:0]     cur_num;
   logic [7:0]     cmds_seen;
   tg_addr_t       exp_raw;
   tg_addr_t       burst_addr;
   tg_burstcount_t beat;

   initial
   begin
      check_count = 0;
      error_count = 0;
   end

   task automatic compare_value(input string what, input tg_data_t expected,
                                input tg_data_t actual);
      check_count = check_count + 1;
      if (expected !== actual)
      begin
         error_count = error_count + 1;
         $display("ERROR %0s %0s: expected %0h actual %0h", cur_name, what, expected, actual);
      end
   endtask

   task automatic report_problem(input string msg);
      error_count = error_count + 1;
      $display("Problem in %0s: %0s", cur_name, msg);
   endtask

   // Burst round-up followed by word round-up and the 4 KB shift
   function automatic tg_addr_t align_address(input tg_addr_t raw, input tg_burstcount_t bc);
      tg_addr_t bc_w;
      tg_addr_t addr;
      tg_addr_t last;
      bc_w = tg_addr_t'(bc);
      addr = (raw / bc_w) * bc_w + bc_w;
      addr = (tg_addr_t'(addr + WORD_DIV) / WORD_DIV) * WORD_DIV;
      last = addr + bc_w - tg_addr_t'(1);
      if ((addr / PAGE_WORDS) != (last / PAGE_WORDS))
         addr = addr + bc_w;
      return addr;
   endfunction

   // First accepted cycle of a command
   task automatic check_command();
      tg_addr_t expected;
      tg_addr_t last;
      cmds_seen = cmds_seen + 8'd1;
      if (cmds_seen > cur_num)
         report_problem("more commands issued than requested");
      compare_value("write flag", tg_data_t'(cur_op == TG_OP_WRITE), tg_data_t'(avl_write));
      compare_value("burstcount", tg_data_t'(cur_bc), tg_data_t'(avl_burstcount));
      // Rules that hold in every mode
      last = avl_address + tg_addr_t'(cur_bc) - tg_addr_t'(1);
      compare_value("word remainder", '0, tg_data_t'(avl_address % WORD_DIV));
      compare_value("page of last word", tg_data_t'(avl_address / PAGE_WORDS),
                    tg_data_t'(last / PAGE_WORDS));
      // The address is a burst multiple plus one word step whether or not it was shifted
      compare_value("burst remainder", '0,
                    tg_data_t'((avl_address - WORD_DIV) % tg_addr_t'(cur_bc)));
      if (cur_mode == TG_MODE_SEQ)
      begin
         expected = align_address(exp_raw, cur_bc);
         compare_value("address", tg_data_t'(expected), tg_data_t'(avl_address));
         // The next raw address continues from the expected aligned address
         exp_raw = expected + tg_addr_t'(cur_bc);
      end
      burst_addr = avl_address;
   endtask

   ////////////////////////////////////////////////////////////
   // Bus monitor sampled on the rising edge
   ////////////////////////////////////////////////////////////
   always @(posedge clk)
   begin
      if (!arst_n)
      begin
         active    = 1'b0;
         cur_name  = "before_start";
         cmds_seen = '0;
         beat      = '0;
      end
      else
      begin
         if (start)
         begin
            active    = 1'b1;
            cur_name  = test_name;
            cur_mode  = cfg_mode;
            cur_op    = cfg_op;
            cur_bc    = cfg_burstcount;
            cur_num   = cfg_num_cmds;
            exp_raw   = cfg_base;
            cmds_seen = '0;
            beat      = '0;
         end
         if (avl_read && avl_write)
            report_problem("read and write requested in the same cycle");
         if (!active && ((avl_read !== 1'b0) || (avl_write !== 1'b0)))
            report_problem("Avalon request while no run is in progress");
         if (active && !avl_waitrequest && (avl_read || avl_write))
         begin
            if (beat == '0)
               check_command();
            if (avl_write)
            begin
               // Later beats keep the address and count of the first beat
               if (beat != '0)
               begin
                  compare_value("burst address", tg_data_t'(burst_addr),
                                tg_data_t'(avl_address));
                  compare_value("burst count", tg_data_t'(cur_bc),
                                tg_data_t'(avl_burstcount));
               end
               // Beat k carries the burst address plus k
               compare_value("write data", tg_data_t'(burst_addr) + tg_data_t'(beat),
                             avl_writedata);
               if (beat == cur_bc - tg_burstcount_t'(1))
                  beat = '0;
               else
                  beat = beat + tg_burstcount_t'(1);
            end
            else if (beat != '0)
            begin
               report_problem("read issued in the middle of a write burst");
            end
         end
         if (done)
         begin
            if (!active)
            begin
               report_problem("done pulsed while no run was in progress");
            end
            else
            begin
               compare_value("command count", tg_data_t'(cur_num), tg_data_t'(cmds_seen));
               if (beat != '0)
                  report_problem("done pulsed before a write burst was complete");
               active = 1'b0;
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: tests/tb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_top
   import tg_avl_pkg::*, tg_cmd_pkg::*;
();

   localparam int CLK_PERIOD = 8;
   localparam int NUM_TESTS  = 7;
   // Worst case per row is 64 commands of 64 beats at 4 cycles a beat
   localparam longint TIMEOUT_NS = longint'(NUM_TESTS) * 64 * 64 * 4 * CLK_PERIOD;

   // One row of the stimulus table with a 12-character name
   typedef struct packed {
      logic [95:0]    name;
      tg_addr_mode_e  mode;
      tg_op_e         op;
      tg_addr_t       base;
      tg_burstcount_t burstcount;
      logic [7:0]     num_cmds;
      logic [1:0]     wait_load;
   } test_row_t;

   logic           clk = 1'b0;
   logic           arst_n;
   logic           start;
   tg_addr_mode_e  cfg_mode;
   tg_op_e         cfg_op;
   tg_addr_t       cfg_base;
   tg_burstcount_t cfg_burstcount;
   logic [7:0]     cfg_num_cmds;
   logic           avl_waitrequest = 1'b0;
   logic           avl_read;
   logic           avl_write;
   tg_addr_t       avl_address;
   tg_burstcount_t avl_burstcount;
   tg_data_t       avl_writedata;
   logic           done;

   logic [95:0]    test_name;
   logic [1:0]     wait_load;
   logic [31:0]    lfsr_state = 32'hfc19;
   logic           bit_a;
   logic           bit_b;
   int             check_count;
   int             error_count;
   test_row_t      rows [NUM_TESTS];

   always #(CLK_PERIOD/2) clk = ~clk;

   tg_top i_dut
   (
      .clk             (clk),
      .arst_n          (arst_n),
      .start           (start),
      .cfg_mode        (cfg_mode),
      .cfg_op          (cfg_op),
      .cfg_base        (cfg_base),
      .cfg_burstcount  (cfg_burstcount),
      .cfg_num_cmds    (cfg_num_cmds),
      .avl_waitrequest (avl_waitrequest),
      .avl_read        (avl_read),
      .avl_write       (avl_write),
      .avl_address     (avl_address),
      .avl_burstcount  (avl_burstcount),
      .avl_writedata   (avl_writedata),
      .done            (done)
   );

   // The checker sees the same pins as the DUT and the current test name
   tb_checker i_checker
   (
      .clk             (clk),
      .arst_n          (arst_n),
      .start           (start),
      .cfg_mode        (cfg_mode),
      .cfg_op          (cfg_op),
      .cfg_base        (cfg_base),
      .cfg_burstcount  (cfg_burstcount),
      .cfg_num_cmds    (cfg_num_cmds),
      .test_name       (test_name),
      .avl_waitrequest (avl_waitrequest),
      .avl_read        (avl_read),
      .avl_write       (avl_write),
      .avl_address     (avl_address),
      .avl_burstcount  (avl_burstcount),
      .avl_writedata   (avl_writedata),
      .done            (done),
      .check_count     (check_count),
      .error_count     (error_count)
   );

   // 32-bit Fibonacci LFSR with taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic test_row_t make_row
   (
      input logic [95:0]    name,
      input tg_addr_mode_e  mode,
      input tg_op_e         op,
      input tg_addr_t       base,
      input tg_burstcount_t burstcount,
      input logic [7:0]     num_cmds,
      input logic [1:0]     load
   );
      test_row_t row;
      row.name       = name;
      row.mode       = mode;
      row.op         = op;
      row.base       = base;
      row.burstcount = burstcount;
      row.num_cmds   = num_cmds;
      row.wait_load  = load;
      return row;
   endfunction

   ////////////////////////////////////////////////////////////
   // Waitrequest load 0 never stalls and 1 stalls half the cycles
   // Load 2 stalls 3 cycles of 4
   ////////////////////////////////////////////////////////////
   always @(negedge clk)
   begin
      case (wait_load)
         2'd1:
         begin
            lfsr_state      = lfsr_step(lfsr_state);
            bit_a           = lfsr_state[0];
            avl_waitrequest = bit_a;
         end
         2'd2:
         begin
            lfsr_state      = lfsr_step(lfsr_state);
            bit_a           = lfsr_state[0];
            lfsr_state      = lfsr_step(lfsr_state);
            bit_b           = lfsr_state[0];
            avl_waitrequest = bit_a | bit_b;
         end
         default:
         begin
            avl_waitrequest = 1'b0;
         end
      endcase
   end

   // Loads one row, pulses start and waits for the end of the run
   task automatic run_row(input test_row_t row);
      // The load level changes on a rising edge away from the waitrequest update
      @(posedge clk);
      wait_load = row.wait_load;
      @(negedge clk);
      test_name      = row.name;
      cfg_mode       = row.mode;
      cfg_op         = row.op;
      cfg_base       = row.base;
      cfg_burstcount = row.burstcount;
      cfg_num_cmds   = row.num_cmds;
      start          = 1'b1;
      @(negedge clk);
      start = 1'b0;
      @(posedge clk);
      while (!done)
         @(posedge clk);
      // A few idle cycles so a second done would be seen by the checker
      repeat (3) @(negedge clk);
   endtask

   initial
   begin
      rows[0] = make_row("seq_write_b8", TG_MODE_SEQ,  TG_OP_WRITE, 24'h000003, 7'd8,  8'd12, 2'd1);
      rows[1] = make_row("seq_read_b32", TG_MODE_SEQ,  TG_OP_READ,  24'h0001C0, 7'd32, 8'd10, 2'd1);
      rows[2] = make_row("rand_read_b4", TG_MODE_RAND, TG_OP_READ,  24'h5A5A5A, 7'd4,  8'd20, 2'd1);
      rows[3] = make_row("rnd_write_16", TG_MODE_RAND, TG_OP_WRITE, 24'h00C0DE, 7'd16, 8'd8,  2'd2);
      rows[4] = make_row("seq_wr_heavy", TG_MODE_SEQ,  TG_OP_WRITE, 24'h0003F0, 7'd64, 8'd6,  2'd2);
      rows[5] = make_row("seq_rd_heavy", TG_MODE_SEQ,  TG_OP_READ,  24'h0FFE00, 7'd1,  8'd40, 2'd2);
      rows[6] = make_row("rnd_write_b2", TG_MODE_RAND, TG_OP_WRITE, 24'h000001, 7'd2,  8'd16, 2'd0);

      arst_n         = 1'b0;
      start          = 1'b0;
      cfg_mode       = TG_MODE_SEQ;
      cfg_op         = TG_OP_READ;
      cfg_base       = '0;
      cfg_burstcount = 7'd1;
      cfg_num_cmds   = 8'd0;
      test_name      = "before_start";
      wait_load      = 2'd1;
      repeat (2) @(negedge clk);
      arst_n = 1'b1;
      // The bus must stay quiet during the idle time after reset
      repeat (5) @(negedge clk);

      for (int i = 0; i < NUM_TESTS; i++)
         run_row(rows[i]);

      repeat (20) @(negedge clk);
      $display("Checks run %0d, errors %0d", check_count, error_count);
      if ((error_count == 0) && (check_count > 0))
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

   // Watchdog against a DUT that never raises done
   initial
   begin
      #(TIMEOUT_NS);
      $display("Timeout, the table did not finish within %0d ns", TIMEOUT_NS);
      $display("Checks run %0d, errors %0d", check_count, error_count);
      $display("ERRORS FOUND");
      $finish;
   end

endmodule

`default_nettype wire

// File: all.f
+incdir+include
verilog/tg_avl_pkg.sv
verilog/tg_cmd_pkg.sv
verilog/tg_burst_boundary_addr_gen.sv
verilog/tg_addr_gen.sv
verilog/tg_cmd_fifo.sv
verilog/tg_avl_cmd_issuer.sv
verilog/tg_top.sv
tests/tb_checker.sv
tests/tb_top.sv

// File: Makefile
.PHONY: all run clean

all: run

# Rebuilt only when a source, a header or the file list changes
obj_dir/Vtb_top: all.f include/tg_defs.svh $(wildcard verilog/*.sv) $(wildcard tests/*.sv)
	verilator --binary --timing --top-module tb_top -f all.f -o Vtb_top

# Passes only when the pass message appears in the simulator output
run: obj_dir/Vtb_top
	@out="$$(./obj_dir/Vtb_top)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'NO ERRORS'

clean:
	rm -rf obj_dir
